//--- hdl/dac_pkg.sv
package dac_pkg;

	// ================================================
	// Widths and counts
	// ================================================
	localparam int SAMPLE_WIDTH = 16;
	localparam int BATCH_SAMPLES = 4;
	localparam int SCALE_WIDTH = 4;
	localparam int MEM_SIZE = 8;
	localparam int DATA_WIDTH = 16;

	// Mailbox slot map.
	localparam int SEED_VALID_ID = 0;
	localparam int TRIG_WAVE_ID = 1;
	localparam int SEED_BASE_ID = 2;

	// ================================================
	// Generator constants
	// ================================================
	// Galois mask for x^16 + x^14 + x^13 + x^11 + 1.
	localparam logic [SAMPLE_WIDTH-1:0] LFSR_TAPS = 16'hB400;
	localparam logic [SAMPLE_WIDTH-1:0] LFSR_ZERO_FILL = 16'hACE1;
	localparam logic [SAMPLE_WIDTH-1:0] TRI_STEP = 16'h0640;
	// Phase advance for one whole batch.
	localparam logic [SAMPLE_WIDTH-1:0] TRI_BATCH_STEP = SAMPLE_WIDTH'(BATCH_SAMPLES * TRI_STEP);

	typedef enum logic [1:0] {
		IDLE,
		SEND_CMD,
		RST_DAC,
		HALT_DAC
	} ctrl_state_t;

	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_RST,
		CMD_HALT,
		CMD_SEED,
		CMD_TRI,
		CMD_SCALE
	} gen_cmd_t;

	typedef enum logic [1:0] {
		MODE_OFF,
		MODE_LFSR,
		MODE_TRI
	} gen_mode_t;

endpackage

//--- hdl/dac_cmd_ctrl.sv
`timescale 1ns/1ps

module dac_cmd_ctrl
	import dac_pkg::*;
(
	input  logic                                      ps_clk,
	input  logic                                      ps_rst,
	input  logic                                      halt,
	input  logic [MEM_SIZE-1:0]                       fresh_bits,
	input  logic [MEM_SIZE-1:0][DATA_WIDTH-1:0]       read_resps,
	input  logic [SCALE_WIDTH-1:0]                    scale_factor_in,
	input  logic                                      cmd_done,
	output logic                                      cmd_valid,
	output gen_cmd_t                                  cmd_op,
	output logic [SCALE_WIDTH-1:0]                    cmd_scale,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] cmd_seeds,
	output logic                                      cmd_ready
);

	ctrl_state_t state_q;
	logic pend_seed_q;
	logic pend_tri_q;
	logic halt_sent_q;
	logic [SCALE_WIDTH-1:0] last_scale_q;

	logic seed_req;
	logic tri_req;
	logic scale_req;
	logic issue;
	gen_cmd_t issue_op;

	// A fresh bit stays pending until its command goes out.
	assign seed_req = pend_seed_q | fresh_bits[SEED_VALID_ID];
	assign tri_req = pend_tri_q | fresh_bits[TRIG_WAVE_ID];
	assign scale_req = (scale_factor_in != last_scale_q);

	// ================================================
	// Command selection
	// ================================================
	always_comb begin
		issue = 1'b0;
		issue_op = CMD_NONE;
		case (state_q)
			RST_DAC: begin
				issue = 1'b1;
				issue_op = CMD_RST;
			end
			IDLE: begin
				if (!halt) begin
					// Seed before triangle before scale.
					if (seed_req) begin
						issue = 1'b1;
						issue_op = CMD_SEED;
					end else if (tri_req) begin
						issue = 1'b1;
						issue_op = CMD_TRI;
					end else if (scale_req) begin
						issue = 1'b1;
						issue_op = CMD_SCALE;
					end
				end
			end
			HALT_DAC: begin
				if (!halt_sent_q) begin
					issue = 1'b1;
					issue_op = CMD_HALT;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state_q <= RST_DAC;
			cmd_valid <= 1'b0;
			cmd_op <= CMD_NONE;
			cmd_scale <= '0;
			cmd_ready <= 1'b0;
			pend_seed_q <= 1'b0;
			pend_tri_q <= 1'b0;
			halt_sent_q <= 1'b0;
			last_scale_q <= '0;
		end else begin
			cmd_valid <= 1'b0;
			if (fresh_bits[SEED_VALID_ID])
				pend_seed_q <= 1'b1;
			if (fresh_bits[TRIG_WAVE_ID])
				pend_tri_q <= 1'b1;

			if (issue) begin
				cmd_valid <= 1'b1;
				cmd_op <= issue_op;
				cmd_scale <= scale_factor_in;
				cmd_ready <= 1'b0;
				state_q <= SEND_CMD;
				// The generator clears its scale on reset.
				if (issue_op != CMD_RST)
					last_scale_q <= scale_factor_in;
				if (issue_op == CMD_SEED)
					pend_seed_q <= 1'b0;
				if (issue_op == CMD_TRI)
					pend_tri_q <= 1'b0;
				if (issue_op == CMD_HALT)
					halt_sent_q <= 1'b1;
			end else begin
				case (state_q)
					IDLE: begin
						if (halt) begin
							state_q <= HALT_DAC;
							cmd_ready <= 1'b0;
						end
					end
					SEND_CMD: begin
						if (cmd_done) begin
							if (halt_sent_q) begin
								state_q <= HALT_DAC;
							end else begin
								state_q <= IDLE;
								cmd_ready <= 1'b1;
							end
						end
					end
					HALT_DAC: begin
						// Halt already sent, wait for release.
						if (!halt) begin
							halt_sent_q <= 1'b0;
							state_q <= IDLE;
							cmd_ready <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Seed words are captured with the seed command.
	always_ff @(posedge ps_clk) begin
		if (issue && issue_op == CMD_SEED) begin
			for (int i = 0; i < BATCH_SAMPLES; i++) begin
				cmd_seeds[i] <= read_resps[SEED_BASE_ID + i];
			end
		end
	end

	a_valid_single: assert property (@(posedge ps_clk) disable iff (ps_rst)
		cmd_valid |=> !cmd_valid);

	a_done_in_send: assert property (@(posedge ps_clk) disable iff (ps_rst)
		cmd_done |-> state_q == SEND_CMD);

endmodule

//--- hdl/lfsr_lane_bank.sv
`timescale 1ns/1ps

module lfsr_lane_bank
	import dac_pkg::*;
(
	input  logic                                       ps_clk,
	input  logic                                       ps_rst,
	input  logic                                       load_seeds,
	input  logic                                       step_lfsr,
	input  logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] seeds,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] lanes
);

	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] next_lanes;
	logic [BATCH_SAMPLES-1:0] lane_zero;
	logic loaded_q;

	// ================================================
	// Galois step and seed fill
	// ================================================
	always_comb begin
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			if (load_seeds) begin
				// Zero would lock the lane.
				next_lanes[i] = (seeds[i] == '0) ? LFSR_ZERO_FILL : seeds[i];
			end else if (step_lfsr) begin
				next_lanes[i] = (lanes[i] >> 1) ^ (lanes[i][0] ? LFSR_TAPS : '0);
			end else begin
				next_lanes[i] = lanes[i];
			end
			lane_zero[i] = (lanes[i] == '0);
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			lanes <= '0;
			loaded_q <= 1'b0;
		end else begin
			lanes <= next_lanes;
			if (load_seeds)
				loaded_q <= 1'b1;
		end
	end

	a_lane_nonzero: assert property (@(posedge ps_clk) disable iff (ps_rst)
		loaded_q |-> lane_zero == '0);

endmodule

//--- hdl/tri_wave_gen.sv
`timescale 1ns/1ps

module tri_wave_gen
	import dac_pkg::*;
(
	input  logic                                       ps_clk,
	input  logic                                       ps_rst,
	input  logic                                       restart_tri,
	input  logic                                       step_tri,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] tri_samples
);

	logic [SAMPLE_WIDTH-1:0] phase_q;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] samp_phase;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] doubled;

	always_ff @(posedge ps_clk) begin
		if (ps_rst || restart_tri) begin
			phase_q <= '0;
		end else if (step_tri) begin
			phase_q <= phase_q + TRI_BATCH_STEP;
		end
	end

	// ================================================
	// Phase to triangle
	// ================================================
	always_comb begin
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			samp_phase[i] = phase_q + SAMPLE_WIDTH'(i) * TRI_STEP;
			doubled[i] = {samp_phase[i][SAMPLE_WIDTH-2:0], 1'b0};
			// Falling half once the top bit is set.
			if (samp_phase[i][SAMPLE_WIDTH-1])
				tri_samples[i] = ~doubled[i];
			else
				tri_samples[i] = doubled[i];
		end
	end

endmodule

//--- hdl/sample_generator.sv
`timescale 1ns/1ps

module sample_generator
	import dac_pkg::*;
(
	input  logic                                       ps_clk,
	input  logic                                       ps_rst,
	input  logic                                       cmd_valid,
	input  gen_cmd_t                                   cmd_op,
	input  logic [SCALE_WIDTH-1:0]                     cmd_scale,
	input  logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] cmd_seeds,
	input  logic                                       dac0_rdy,
	output logic                                       cmd_done,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_batch,
	output logic                                       valid_dac_batch
);

	gen_mode_t mode_q;
	logic [SCALE_WIDTH-1:0] scale_q;

	logic accept;
	logic step_lfsr;
	logic step_tri;
	logic load_seeds;
	logic restart_tri;
	logic lane_clear;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] lanes;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] tri_samples;

	// ================================================
	// Command decode
	// ================================================
	assign load_seeds = cmd_valid && (cmd_op == CMD_SEED);
	assign restart_tri = cmd_valid && (cmd_op == CMD_TRI);
	assign lane_clear = ps_rst || (cmd_valid && (cmd_op == CMD_RST));

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			mode_q <= MODE_OFF;
			scale_q <= '0;
			cmd_done <= 1'b0;
		end else begin
			cmd_done <= cmd_valid;
			if (cmd_valid) begin
				case (cmd_op)
					CMD_RST: begin
						mode_q <= MODE_OFF;
						scale_q <= '0;
					end
					CMD_HALT: begin
						mode_q <= MODE_OFF;
						scale_q <= cmd_scale;
					end
					CMD_SEED: begin
						mode_q <= MODE_LFSR;
						scale_q <= cmd_scale;
					end
					CMD_TRI: begin
						mode_q <= MODE_TRI;
						scale_q <= cmd_scale;
					end
					CMD_SCALE: scale_q <= cmd_scale;
					default: ;
				endcase
			end
		end
	end

	// Sources only move on an accepted batch.
	assign valid_dac_batch = (mode_q != MODE_OFF);
	assign accept = valid_dac_batch && dac0_rdy;
	assign step_lfsr = accept && (mode_q == MODE_LFSR);
	assign step_tri = accept && (mode_q == MODE_TRI);

	lfsr_lane_bank i_lfsr (
		.ps_clk    (ps_clk),
		.ps_rst    (lane_clear),
		.load_seeds(load_seeds),
		.step_lfsr (step_lfsr),
		.seeds     (cmd_seeds),
		.lanes     (lanes)
	);

	tri_wave_gen i_tri (
		.ps_clk     (ps_clk),
		.ps_rst     (ps_rst),
		.restart_tri(restart_tri),
		.step_tri   (step_tri),
		.tri_samples(tri_samples)
	);

	always_comb begin
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			if (mode_q == MODE_TRI)
				dac_batch[i] = tri_samples[i] >> scale_q;
			else
				dac_batch[i] = lanes[i] >> scale_q;
		end
	end

	a_stop_on_halt: assert property (@(posedge ps_clk) disable iff (ps_rst)
		cmd_valid && (cmd_op == CMD_HALT || cmd_op == CMD_RST) |=> !valid_dac_batch);

endmodule

//--- hdl/dac_interface.sv
`timescale 1ns/1ps

module dac_interface
	import dac_pkg::*;
(
	input  logic                                       ps_clk,
	input  logic                                       ps_rst,
	input  logic [MEM_SIZE-1:0]                        fresh_bits,
	input  logic [MEM_SIZE-1:0][DATA_WIDTH-1:0]        read_resps,
	input  logic [SCALE_WIDTH-1:0]                     scale_factor_in,
	input  logic                                       halt,
	input  logic                                       dac0_rdy,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_batch,
	output logic                                       valid_dac_batch,
	output logic                                       cmd_ready
);

	logic cmd_valid;
	gen_cmd_t cmd_op;
	logic [SCALE_WIDTH-1:0] cmd_scale;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] cmd_seeds;
	logic cmd_done;

	dac_cmd_ctrl i_ctrl (
		.ps_clk         (ps_clk),
		.ps_rst         (ps_rst),
		.halt           (halt),
		.fresh_bits     (fresh_bits),
		.read_resps     (read_resps),
		.scale_factor_in(scale_factor_in),
		.cmd_done       (cmd_done),
		.cmd_valid      (cmd_valid),
		.cmd_op         (cmd_op),
		.cmd_scale      (cmd_scale),
		.cmd_seeds      (cmd_seeds),
		.cmd_ready      (cmd_ready)
	);

	sample_generator i_gen (
		.ps_clk         (ps_clk),
		.ps_rst         (ps_rst),
		.cmd_valid      (cmd_valid),
		.cmd_op         (cmd_op),
		.cmd_scale      (cmd_scale),
		.cmd_seeds      (cmd_seeds),
		.dac0_rdy       (dac0_rdy),
		.cmd_done       (cmd_done),
		.dac_batch      (dac_batch),
		.valid_dac_batch(valid_dac_batch)
	);

endmodule

//--- tb/dac_interface_tb.sv
`timescale 1ns/1ps

module dac_interface_tb
	import dac_pkg::*;
();

	localparam int NUM_ROWS = 10;
	localparam logic [SAMPLE_WIDTH-1:0] NO_SEED = '0;

	typedef enum int {ACT_RESET, ACT_SEED, ACT_TRI, ACT_SCALE, ACT_HALT, ACT_RELEASE} act_t;

	logic ps_clk;
	logic ps_rst;
	logic [MEM_SIZE-1:0] fresh_bits;
	logic [MEM_SIZE-1:0][DATA_WIDTH-1:0] read_resps;
	logic [SCALE_WIDTH-1:0] scale_factor_in;
	logic halt;
	logic dac0_rdy;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_batch;
	logic valid_dac_batch;
	logic cmd_ready;

	// Stimulus table, one entry per test.
	string row_name [NUM_ROWS];
	act_t row_act [NUM_ROWS];
	logic [SAMPLE_WIDTH-1:0] row_seed [NUM_ROWS][BATCH_SAMPLES];
	logic [SCALE_WIDTH-1:0] row_scale [NUM_ROWS];
	int row_batches [NUM_ROWS];
	logic [7:0] row_stall [NUM_ROWS];
	int num_rows = 0;

	// Reference model state.
	logic [SAMPLE_WIDTH-1:0] m_lane [BATCH_SAMPLES];
	logic [SAMPLE_WIDTH-1:0] m_phase;
	gen_mode_t m_mode;
	logic [SCALE_WIDTH-1:0] m_scale;

	string cur_name;
	int err_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	dac_interface i_dut (
		.ps_clk         (ps_clk),
		.ps_rst         (ps_rst),
		.fresh_bits     (fresh_bits),
		.read_resps     (read_resps),
		.scale_factor_in(scale_factor_in),
		.halt           (halt),
		.dac0_rdy       (dac0_rdy),
		.dac_batch      (dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.cmd_ready      (cmd_ready)
	);

	initial begin
		ps_clk = 1'b0;
		forever #2 ps_clk = ~ps_clk;
	end

	always @(posedge ps_clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("TIMEOUT in %s: the run went past %0d cycles", cur_name, cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// ================================================
	// Reference model
	// ================================================
	function automatic logic [SAMPLE_WIDTH-1:0] lfsr_next(input logic [SAMPLE_WIDTH-1:0] x);
		logic [SAMPLE_WIDTH-1:0] y;
		y = x >> 1;
		if (x[0])
			y = y ^ LFSR_TAPS;
		return y;
	endfunction

	// Doubled phase, inverted on the falling half.
	function automatic logic [SAMPLE_WIDTH-1:0] tri_value(input logic [SAMPLE_WIDTH-1:0] p);
		logic [SAMPLE_WIDTH-1:0] d;
		d = p << 1;
		return p[SAMPLE_WIDTH-1] ? ~d : d;
	endfunction

	task automatic advance_model();
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			if (m_mode == MODE_LFSR)
				m_lane[i] = lfsr_next(m_lane[i]);
			if (m_mode == MODE_TRI)
				m_phase = m_phase + TRI_STEP;
		end
	endtask

	task automatic add_row(input string name, input act_t act,
		input logic [SAMPLE_WIDTH-1:0] s0, input logic [SAMPLE_WIDTH-1:0] s1,
		input logic [SAMPLE_WIDTH-1:0] s2, input logic [SAMPLE_WIDTH-1:0] s3,
		input logic [SCALE_WIDTH-1:0] scale, input int batches, input logic [7:0] stall);
		row_name[num_rows] = name;
		row_act[num_rows] = act;
		row_seed[num_rows][0] = s0;
		row_seed[num_rows][1] = s1;
		row_seed[num_rows][2] = s2;
		row_seed[num_rows][3] = s3;
		row_scale[num_rows] = scale;
		row_batches[num_rows] = batches;
		row_stall[num_rows] = stall;
		num_rows++;
	endtask

	task automatic check_value(input string what, input logic [SAMPLE_WIDTH-1:0] exp,
		input logic [SAMPLE_WIDTH-1:0] act);
		assert (act === exp) else begin
			$display("ERROR %s %s: expected %h actual %h", cur_name, what, exp, act);
			err_count++;
		end
	endtask

	// ================================================
	// Stimulus helpers
	// ================================================
	task automatic wait_ready();
		@(negedge ps_clk);
		while (!cmd_ready)
			@(negedge ps_clk);
	endtask

	task automatic check_idle(input int n);
		repeat (n) begin
			@(negedge ps_clk);
			check_value("valid_dac_batch", 16'd0, 16'(valid_dac_batch));
		end
	endtask

	task automatic send_cmd(input int r);
		@(posedge ps_clk);
		scale_factor_in <= row_scale[r];
		if (row_act[r] == ACT_SEED) begin
			for (int i = 0; i < BATCH_SAMPLES; i++)
				read_resps[SEED_BASE_ID + i] <= row_seed[r][i];
			fresh_bits[SEED_VALID_ID] <= 1'b1;
		end else if (row_act[r] == ACT_TRI) begin
			fresh_bits[TRIG_WAVE_ID] <= 1'b1;
		end
		@(posedge ps_clk);
		fresh_bits <= '0;
		wait_ready();
	endtask

	// Stalled cycles must show the same batch again.
	task automatic collect_batches(input int r);
		int taken;
		int c;
		logic rdy;
		logic [SAMPLE_WIDTH-1:0] p;
		logic [SAMPLE_WIDTH-1:0] src;
		taken = 0;
		c = 0;
		while (taken < row_batches[r]) begin
			@(posedge ps_clk);
			rdy = (c < 8) ? !row_stall[r][c[2:0]] : 1'b1;
			dac0_rdy <= rdy;
			@(negedge ps_clk);
			check_value("valid_dac_batch", 16'd1, 16'(valid_dac_batch));
			p = m_phase;
			for (int i = 0; i < BATCH_SAMPLES; i++) begin
				src = (m_mode == MODE_TRI) ? tri_value(p) : m_lane[i];
				check_value($sformatf("sample %0d", i), src >> m_scale, dac_batch[i]);
				p = p + TRI_STEP;
			end
			if (rdy) begin
				taken++;
				advance_model();
			end
			c++;
		end
		@(posedge ps_clk);
		dac0_rdy <= 1'b0;
	endtask

	task automatic apply_row(input int r);
		int errs_before;
		errs_before = err_count;
		cur_name = row_name[r];
		case (row_act[r])
			ACT_RESET: begin
				@(posedge ps_clk);
				ps_rst <= 1'b1;
				repeat (10) @(posedge ps_clk);
				ps_rst <= 1'b0;
				for (int i = 0; i < BATCH_SAMPLES; i++)
					m_lane[i] = '0;
				m_phase = '0;
				m_mode = MODE_OFF;
				m_scale = '0;
				@(negedge ps_clk);
				check_value("cmd_ready", 16'd0, 16'(cmd_ready));
				check_value("valid_dac_batch", 16'd0, 16'(valid_dac_batch));
				wait_ready();
				check_idle(row_batches[r]);
			end
			ACT_SEED: begin
				send_cmd(r);
				for (int i = 0; i < BATCH_SAMPLES; i++)
					m_lane[i] = (row_seed[r][i] == '0) ? LFSR_ZERO_FILL : row_seed[r][i];
				m_mode = MODE_LFSR;
				m_scale = row_scale[r];
				collect_batches(r);
			end
			ACT_TRI: begin
				send_cmd(r);
				m_phase = '0;
				m_mode = MODE_TRI;
				m_scale = row_scale[r];
				collect_batches(r);
			end
			ACT_SCALE: begin
				send_cmd(r);
				m_scale = row_scale[r];
				collect_batches(r);
			end
			ACT_HALT: begin
				@(posedge ps_clk);
				halt <= 1'b1;
				@(negedge ps_clk);
				while (valid_dac_batch)
					@(negedge ps_clk);
				m_mode = MODE_OFF;
				repeat (row_batches[r]) begin
					@(negedge ps_clk);
					check_value("valid_dac_batch", 16'd0, 16'(valid_dac_batch));
					check_value("cmd_ready", 16'd0, 16'(cmd_ready));
				end
			end
			ACT_RELEASE: begin
				@(posedge ps_clk);
				halt <= 1'b0;
				wait_ready();
				check_idle(row_batches[r]);
			end
			default: ;
		endcase
		if (err_count == errs_before) begin
			$display("PASS %s", cur_name);
			pass_count++;
		end else begin
			$display("FAIL %s with %0d errors", cur_name, err_count - errs_before);
			fail_count++;
		end
	endtask

	task automatic build_table();
		add_row("reset_idle", ACT_RESET, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd0, 6, 8'h00);
		add_row("seed_fixed", ACT_SEED, 16'h1234, 16'h0000, 16'hbeef, 16'h8001,
			4'd0, 12, 8'h00);
		add_row("seed_random", ACT_SEED, 16'($urandom), 16'($urandom), 16'($urandom),
			16'($urandom), 4'($urandom % 4), 10, 8'b0010_1100);
		add_row("scale_change", ACT_SCALE, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd5, 8, 8'h00);
		add_row("tri_wave", ACT_TRI, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd0, 24,
			8'b1001_0010);
		add_row("tri_scale", ACT_SCALE, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd3, 10,
			8'b0000_0110);
		add_row("halt_hold", ACT_HALT, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd3, 8, 8'h00);
		add_row("halt_release", ACT_RELEASE, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd3, 4, 8'h00);
		add_row("tri_restart", ACT_TRI, NO_SEED, NO_SEED, NO_SEED, NO_SEED, 4'd2, 8, 8'h00);
		add_row("seed_stall", ACT_SEED, 16'($urandom), 16'($urandom), 16'($urandom),
			16'($urandom), 4'd1, 6, 8'b1111_0000);
	endtask

	// ================================================
	// Main sequence
	// ================================================
	initial begin
		int total;
		ps_rst = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		scale_factor_in = '0;
		halt = 1'b0;
		dac0_rdy = 1'b0;
		cur_name = "startup";
		void'($urandom(32'heb2c_8224));
		build_table();
		total = 0;
		for (int r = 0; r < num_rows; r++)
			total += row_batches[r] + $countones(row_stall[r]) + 40;
		cycle_limit = total;
		for (int r = 0; r < num_rows; r++)
			apply_row(r);
		$display("Tests: %0d passed, %0d failed, %0d check errors",
			pass_count, fail_count, err_count);
		if (err_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- dac_interface.f
hdl/dac_pkg.sv
hdl/dac_cmd_ctrl.sv
hdl/lfsr_lane_bank.sv
hdl/tri_wave_gen.sv
hdl/sample_generator.sv
hdl/dac_interface.sv
tb/dac_interface_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

TOP=dac_interface_tb
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	-f dac_interface.f \
	-o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -qx "Simulation completed successfully" "$LOG"; then
	echo "Run passed"
	exit 0
else
	echo "Run failed, see $LOG"
	exit 1
fi
